//--- source/core_cfg_pkg.sv
// system constants of the core: data width, register index width, reset vector, pc step
`default_nettype none

package core_cfg_pkg;

  localparam int unsigned xlen = 32;  // data and byte address width

  // 32 architectural registers
  localparam int unsigned reg_idx_w = 5;

  // boot rom address, first fetch after reset
  localparam logic [xlen-1:0] reset_vector = 32'hBFC0_0000;

  localparam logic [xlen-1:0] instr_bytes = 32'd4;  // pc step per instruction

endpackage

`default_nettype wire

//--- source/mips_isa_pkg.sv
// opcode, funct and register index constants for the supported mips subset
`default_nettype none

package mips_isa_pkg;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'b000000;  // funct selects the operation
  localparam logic [5:0] op_beq   = 6'b000100;
  localparam logic [5:0] op_bne   = 6'b000101;
  localparam logic [5:0] op_addiu = 6'b001001;
  localparam logic [5:0] op_ori   = 6'b001101;
  localparam logic [5:0] op_lui   = 6'b001111;

  // funct field of r-type, instr[5:0]
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_slt  = 6'b101010;

  // register file geometry
  localparam logic [4:0] reg_v0_idx = 5'd2;  // return value register
  localparam int unsigned num_regs  = 32;

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
// fetch unit: pc register, next pc and branch target, wishbone classic read master
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import core_cfg_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            branch_taken,  // from execute, only meaningful with instr_valid
  input  logic            wb_ack,
  input  logic [xlen-1:0] wb_rdata,
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic [xlen-1:0] wb_adr,        // byte address
  output logic [31:0]     instr,
  output logic [xlen-1:0] pc,
  output logic            instr_valid
);

  typedef enum logic [1:0] {
    st_request,  // bus cycle open, waiting for ack
    st_deliver,  // instruction handed to execute, pc loads at end
    st_update    // bus idle for one cycle
  } state_t;

  state_t          state;
  state_t          state_next;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] branch_off;
  logic [xlen-1:0] branch_target;
  logic [xlen-1:0] pc_next;

  always_comb begin
    state_next = state;
    case (state)
      st_request: if (wb_ack) state_next = st_deliver;  // any number of wait states
      st_deliver: state_next = st_update;
      st_update:  state_next = st_request;
      default:    state_next = st_update;
    endcase
  end

  // reset parks the fsm in update, so the first edge after reset opens the fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_update;
      pc    <= reset_vector;
    end else begin
      state <= state_next;
      if (state == st_deliver) pc <= pc_next;
    end
  end

  // instruction holding register
  always_ff @(posedge clk) begin
    if (state == st_request && wb_ack) instr <= wb_rdata[31:0];
  end

  // branch offset is a word count relative to the following instruction
  assign pc_plus4      = pc + instr_bytes;
  assign branch_off    = {{(xlen-18){instr[15]}}, instr[15:0], 2'b00};
  assign branch_target = pc_plus4 + branch_off;
  assign pc_next       = branch_taken ? branch_target : pc_plus4;  // no delay slot

  assign wb_cyc      = (state == st_request);
  assign wb_stb      = wb_cyc;  // single transfer per cycle
  assign wb_adr      = pc;      // pc only moves in deliver, so address holds while waiting
  assign instr_valid = (state == st_deliver);

  a_stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // address must hold through wait states until the slave acks
  a_adr_stable: assert property (@(posedge clk) disable iff (reset)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else $error("wb_adr changed or request dropped before wb_ack");

endmodule

`default_nettype wire

//--- source/reg_file.sv
// 32 entry register file: two combinational reads, one write, r0 fixed at zero, v0 tap
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import core_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 we,
  input  logic [reg_idx_w-1:0] wa,
  input  logic [xlen-1:0]      wd,
  input  logic [reg_idx_w-1:0] ra1,
  input  logic [reg_idx_w-1:0] ra2,
  output logic [xlen-1:0]      rd1,
  output logic [xlen-1:0]      rd2,
  output logic [xlen-1:0]      reg_v0
);

  logic [xlen-1:0] rf [2**reg_idx_w];

  // write lands on the edge that closes the execute cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_idx_w; i++) begin
        rf[i] <= '0;  // architectural state starts cleared
      end
    end else if (we && wa != '0) begin
      rf[wa] <= wd;   // r0 writes dropped
    end
  end

  // read ports, r0 always reads zero
  assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
  assign rd2 = (ra2 == '0) ? '0 : rf[ra2];

  assign reg_v0 = rf[2];  // v0 is r2

  // write data comes from the alu in another module, catch x from bad decode
  a_wd_known: assert property (@(posedge clk) disable iff (reset)
    we |-> !$isunknown(wd))
    else $error("register write with unknown data to r%0d", wa);

endmodule

`default_nettype wire

//--- source/execute_unit.sv
// execute unit: decode, immediate extension, alu, branch compare, write-back and retire trace
`timescale 1ns/1ps
`default_nettype none

module execute_unit
  import core_cfg_pkg::*;
  import mips_isa_pkg::*;
(
  input  logic [31:0]          instr,
  input  logic [xlen-1:0]      pc,
  input  logic                 instr_valid,
  input  logic [xlen-1:0]      rd1,         // rs value
  input  logic [xlen-1:0]      rd2,         // rt value
  output logic [reg_idx_w-1:0] ra1,
  output logic [reg_idx_w-1:0] ra2,
  output logic                 we,
  output logic [reg_idx_w-1:0] wa,
  output logic [xlen-1:0]      wd,
  output logic                 branch_taken,
  output logic                 retire_valid,
  output logic [xlen-1:0]      retire_pc,
  output logic                 retire_wr_en,
  output logic [reg_idx_w-1:0] retire_wr_addr,
  output logic [xlen-1:0]      retire_wr_data
);

  logic [5:0]           opcode;
  logic [5:0]           funct;
  logic [reg_idx_w-1:0] rs;
  logic [reg_idx_w-1:0] rt;
  logic [reg_idx_w-1:0] rd;
  logic [15:0]          imm;
  logic [xlen-1:0]      imm_sext;
  logic [xlen-1:0]      imm_zext;
  logic [xlen-1:0]      imm_hi;
  logic                 src_eq;
  logic                 writes_reg;  // instruction has a register result
  logic                 take;
  logic [reg_idx_w-1:0] dest;
  logic [xlen-1:0]      result;

  // field split
  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign funct  = instr[5:0];
  assign imm    = instr[15:0];

  assign imm_sext = {{(xlen-16){imm[15]}}, imm};  // addiu
  assign imm_zext = {{(xlen-16){1'b0}}, imm};     // ori
  assign imm_hi   = {imm, 16'b0};                 // lui

  assign ra1    = rs;
  assign ra2    = rt;
  assign src_eq = (rd1 == rd2);

  always_comb begin
    writes_reg = 1'b0;
    take       = 1'b0;
    dest       = rt;   // i-type default
    result     = '0;
    case (opcode)
      op_rtype: begin
        dest = rd;
        writes_reg = 1'b1;
        case (funct)
          fn_addu: result = rd1 + rd2;  // wraps, no overflow trap
          fn_subu: result = rd1 - rd2;
          fn_and:  result = rd1 & rd2;
          fn_or:   result = rd1 | rd2;
          fn_slt:  result = {{(xlen-1){1'b0}}, $signed(rd1) < $signed(rd2)};
          default: writes_reg = 1'b0;   // unsupported funct retires as nop
        endcase
      end
      op_addiu: begin
        writes_reg = 1'b1;
        result = rd1 + imm_sext;
      end
      op_ori: begin
        writes_reg = 1'b1;
        result = rd1 | imm_zext;
      end
      op_lui: begin
        writes_reg = 1'b1;
        result = imm_hi;
      end
      op_beq: take = src_eq;
      op_bne: take = !src_eq;
      default: ;  // anything else is a nop
    endcase
  end

  // write port, r0 destination suppressed here so the trace shows no write
  assign we = instr_valid && writes_reg && (dest != '0);
  assign wa = dest;
  assign wd = result;

  assign branch_taken = instr_valid && take;

  // trace mirrors the write port in the execute cycle
  assign retire_valid   = instr_valid;
  assign retire_pc      = pc;
  assign retire_wr_en   = we;
  assign retire_wr_addr = wa;
  assign retire_wr_data = wd;

endmodule

`default_nettype wire

//--- source/mips_core.sv
// top level of the core: fetch unit, register file and execute unit
`timescale 1ns/1ps
`default_nettype none

module mips_core
  import core_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic [xlen-1:0]      wb_adr,
  input  logic [xlen-1:0]      wb_rdata,
  input  logic                 wb_ack,
  output logic [xlen-1:0]      reg_v0,
  output logic                 retire_valid,
  output logic [xlen-1:0]      retire_pc,
  output logic                 retire_wr_en,
  output logic [reg_idx_w-1:0] retire_wr_addr,
  output logic [xlen-1:0]      retire_wr_data
);

  logic [31:0]          instr;
  logic [xlen-1:0]      pc;
  logic                 instr_valid;
  logic                 branch_taken;
  logic [reg_idx_w-1:0] ra1;
  logic [reg_idx_w-1:0] ra2;
  logic [xlen-1:0]      rd1;
  logic [xlen-1:0]      rd2;
  logic                 we;
  logic [reg_idx_w-1:0] wa;
  logic [xlen-1:0]      wd;

  fetch_unit i_fetch_unit (
    .clk, .reset, .branch_taken, .wb_ack, .wb_rdata,
    .wb_cyc, .wb_stb, .wb_adr, .instr, .pc, .instr_valid
  );

  reg_file i_reg_file (
    .clk, .reset, .we, .wa, .wd, .ra1, .ra2, .rd1, .rd2, .reg_v0
  );

  // purely combinational, works in the instr_valid cycle
  execute_unit i_execute_unit (
    .instr, .pc, .instr_valid, .rd1, .rd2, .ra1, .ra2, .we, .wa, .wd, .branch_taken,
    .retire_valid, .retire_pc, .retire_wr_en, .retire_wr_addr, .retire_wr_data
  );

  // execute samples branch_taken and writes back once per pulse, so the pulse is one cycle
  a_valid_single: assert property (@(posedge clk) disable iff (reset)
    instr_valid |=> !instr_valid)
    else $error("instr_valid high on two consecutive cycles");

endmodule

`default_nettype wire

//--- tests/core_checker.sv
// checker: reference model of the core, bus protocol checks, retire and v0 compare, error counts
`timescale 1ns/1ps
`default_nettype none

module core_checker
  import core_cfg_pkg::*;
  import mips_isa_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic [xlen-1:0]      wb_adr,
  input  logic [xlen-1:0]      wb_rdata,
  input  logic                 wb_ack,
  input  logic [xlen-1:0]      reg_v0,
  input  logic                 retire_valid,
  input  logic [xlen-1:0]      retire_pc,
  input  logic                 retire_wr_en,
  input  logic [reg_idx_w-1:0] retire_wr_addr,
  input  logic [xlen-1:0]      retire_wr_data,
  output int                   retired,
  output int                   mismatches,
  output int                   protocol_errors
);

  logic [xlen-1:0] model_reg [num_regs];
  logic [xlen-1:0] model_pc;
  logic [31:0]     fetched;               // word captured on the last ack
  logic [xlen-1:0] req_adr;
  logic            in_req      = 1'b0;
  logic            ack_pending = 1'b0;    // fetched, not yet retired
  logic            reset_seen  = 1'b0;    // dut state known after first reset edge
  int              n_retired   = 0;
  int              n_mismatch  = 0;
  int              n_protocol  = 0;

  assign retired         = n_retired;
  assign mismatches      = n_mismatch;
  assign protocol_errors = n_protocol;

  task automatic value_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] want);
    $display("Mismatch at %0t: %s is %h, expected %h (instr %h, pc %h)",
             $time, what, got, want, fetched, model_pc);
    n_mismatch++;
  endtask

  task automatic protocol_fault(input string what);
    $display("protocol error at %0t: %s", $time, what);
    n_protocol++;
  endtask

  // expected effect of one instruction on the model state
  task automatic predict(input logic [31:0] ins, output logic en, output logic [4:0] addr,
                         output logic [xlen-1:0] data, output logic [xlen-1:0] next_pc);
    logic [5:0]      op;
    logic [xlen-1:0] s;
    logic [xlen-1:0] t;
    logic [xlen-1:0] seq_pc;
    op      = ins[31:26];
    s       = model_reg[ins[25:21]];
    t       = model_reg[ins[20:16]];
    seq_pc  = model_pc + instr_bytes;
    en      = 1'b1;
    addr    = ins[20:16];  // i-type writes rt
    data    = '0;
    next_pc = seq_pc;
    if (op == op_rtype) begin
      addr = ins[15:11];
      if (ins[5:0] == fn_addu) data = s + t;
      else if (ins[5:0] == fn_subu) data = s - t;
      else if (ins[5:0] == fn_and) data = s & t;
      else if (ins[5:0] == fn_or) data = s | t;
      else if (ins[5:0] == fn_slt) data = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
      else en = 1'b0;
    end else if (op == op_addiu) data = s + {{16{ins[15]}}, ins[15:0]};
    else if (op == op_ori) data = s | {16'h0000, ins[15:0]};
    else if (op == op_lui) data = {ins[15:0], 16'h0000};
    else begin
      en = 1'b0;  // branches and unknown encodings write nothing
      if ((op == op_beq && s == t) || (op == op_bne && s != t))
        next_pc = seq_pc + {{14{ins[15]}}, ins[15:0], 2'b00};  // no delay slot
    end
    if (addr == 5'd0) en = 1'b0;  // r0 stays zero
  endtask

  task automatic check_retire();
    logic            en;
    logic [4:0]      addr;
    logic [xlen-1:0] data;
    logic [xlen-1:0] next_pc;
    predict(fetched, en, addr, data, next_pc);
    if (retire_pc !== model_pc) value_mismatch("retire_pc", retire_pc, model_pc);
    if (retire_wr_en !== en) begin
      value_mismatch("retire_wr_en", 32'(retire_wr_en), 32'(en));
    end else if (en) begin
      if (retire_wr_addr !== addr)
        value_mismatch("retire_wr_addr", 32'(retire_wr_addr), 32'(addr));
      if (retire_wr_data !== data) value_mismatch("retire_wr_data", retire_wr_data, data);
    end
    if (en) model_reg[addr] = data;
    model_pc = next_pc;
    n_retired++;
  endtask

  // samples at the rising edge, so all values are the ones before the edge
  always @(posedge clk) begin
    if (reset) begin
      if (reset_seen && (wb_cyc !== 1'b0 || wb_stb !== 1'b0))
        protocol_fault("bus request active during reset");
      reset_seen = 1'b1;
      for (int i = 0; i < num_regs; i++) model_reg[i] = '0;
      model_pc    = reset_vector;
      in_req      = 1'b0;
      ack_pending = 1'b0;
    end else begin
      // v0 compared before this edge's write lands
      if (reg_v0 !== model_reg[reg_v0_idx]) value_mismatch("reg_v0", reg_v0, model_reg[2]);
      if (wb_stb === 1'b1 && wb_cyc !== 1'b1) protocol_fault("wb_stb high without wb_cyc");
      if (wb_cyc === 1'b1 && wb_stb === 1'b1) begin
        if (!in_req) begin
          if (wb_adr !== model_pc) value_mismatch("fetch wb_adr", wb_adr, model_pc);
          req_adr = wb_adr;
          in_req  = 1'b1;
        end else if (wb_adr !== req_adr) begin
          protocol_fault("wb_adr changed while waiting for wb_ack");
        end
        if (wb_ack === 1'b1) begin
          if (ack_pending) protocol_fault("new ack before the last instruction retired");
          fetched     = wb_rdata;
          ack_pending = 1'b1;
          in_req      = 1'b0;
        end
      end
      if (retire_valid === 1'b1) begin
        if (!ack_pending) protocol_fault("retirement without a fetched instruction");
        else check_retire();
        ack_pending = 1'b0;  // exactly one retirement per ack
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_mips_core.sv
// testbench top: clock, reset, lfsr program generator, wishbone memory with wait states, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core
  import core_cfg_pkg::*;
  import mips_isa_pkg::*;
();

  localparam int half_period    = 20;    // 40 ns clock
  localparam int prog_words     = 256;
  localparam int max_retire     = 200;
  localparam int timeout_cycles = 2000;  // 200 x (4 + 3) + reset + margin
  localparam logic [xlen-1:0] prog_bytes = 32'd1024;

  logic                 clk;
  logic                 reset;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic [xlen-1:0]      wb_adr;
  logic [xlen-1:0]      wb_rdata;
  logic                 wb_ack;
  logic [xlen-1:0]      reg_v0;
  logic                 retire_valid;
  logic [xlen-1:0]      retire_pc;
  logic                 retire_wr_en;
  logic [reg_idx_w-1:0] retire_wr_addr;
  logic [xlen-1:0]      retire_wr_data;

  int retired;          // counts kept by the checker
  int mismatches;
  int protocol_errors;
  int timeouts = 0;
  int cycles   = 0;
  logic done   = 1'b0;

  logic [31:0] prog [prog_words];  // program image at reset_vector
  logic [31:0] lfsr = 32'd80;      // fibonacci lfsr, taps 32 22 2 1
  logic        busy = 1'b0;        // slave has seen the current request
  logic [1:0]  waits_left = 2'd0;

  mips_core i_mips_core (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_rdata, .wb_ack, .reg_v0,
    .retire_valid, .retire_pc, .retire_wr_en, .retire_wr_addr, .retire_wr_data
  );

  core_checker i_core_checker (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_rdata, .wb_ack, .reg_v0,
    .retire_valid, .retire_pc, .retire_wr_en, .retire_wr_addr, .retire_wr_data,
    .retired, .mismatches, .protocol_errors
  );

  // one lfsr step per bit, newest bit ends up in the lsb
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // registers limited to r0..r7 so results feed each other and hit v0 often
  function automatic logic [31:0] random_instr();
    logic [4:0]  kind;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    kind = 5'(take_bits(5));
    rs   = {2'b00, 3'(take_bits(3))};
    rt   = {2'b00, 3'(take_bits(3))};
    rd   = {2'b00, 3'(take_bits(3))};
    imm  = 16'(take_bits(16));
    case (kind) inside
      [5'd0:5'd1]:   return {6'b100011, rs, rt, imm};  // lw, not supported
      5'd2:          return {op_rtype, rs, rt, rd, 5'd0, 6'b000000};  // sll funct
      [5'd3:5'd5]:   return {op_rtype, rs, rt, rd, 5'd0, fn_addu};
      [5'd6:5'd7]:   return {op_rtype, rs, rt, rd, 5'd0, fn_subu};
      [5'd8:5'd9]:   return {op_rtype, rs, rt, rd, 5'd0, fn_and};
      [5'd10:5'd11]: return {op_rtype, rs, rt, rd, 5'd0, fn_or};
      [5'd12:5'd14]: return {op_rtype, rs, rt, rd, 5'd0, fn_slt};
      [5'd15:5'd18]: return {op_addiu, rs, rt, imm};
      [5'd19:5'd21]: return {op_ori, rs, rt, imm};
      [5'd22:5'd24]: return {op_lui, 5'd0, rt, imm};
      [5'd25:5'd28]: return {op_beq, rs, rt, 14'd0, 2'(take_bits(2))};  // forward only
      default:       return {op_bne, rs, rt, 14'd0, 2'(take_bits(2))};
    endcase
  endfunction

  function automatic logic in_window(input logic [xlen-1:0] a);
    logic [xlen-1:0] off;
    off = a - reset_vector;
    return off < prog_bytes;
  endfunction

  // outside the program an unsupported opcode tagged with the address
  function automatic logic [31:0] fetch_word(input logic [xlen-1:0] a);
    logic [xlen-1:0] off;
    off = a - reset_vector;
    if (in_window(a)) return prog[off[9:2]];
    return {6'b111111, a[27:2]};
  endfunction

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  // wishbone slave, 0..3 wait states drawn per request
  always @(negedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
    end else if (wb_cyc && wb_stb && !wb_ack) begin
      if (!busy) begin
        busy       = 1'b1;
        waits_left = 2'(take_bits(2));
      end
      if (waits_left == 2'd0) begin
        wb_ack   <= 1'b1;
        wb_rdata <= fetch_word(wb_adr);
        busy = 1'b0;
      end else begin
        waits_left = waits_left - 2'd1;
      end
    end else begin
      wb_ack <= 1'b0;  // cycle closed after the ack edge
    end
  end

  initial begin
    reset    = 1'b1;
    wb_ack   = 1'b0;
    wb_rdata = '0;
    for (int i = 0; i < prog_words; i++) prog[i] = random_instr();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;
    while (!done && cycles < timeout_cycles) begin
      @(negedge clk);
      if (retired >= max_retire) begin
        done = 1'b1;
      end else if (wb_cyc && !in_window(wb_adr)) begin
        @(negedge clk);  // pc left the program, checker still compares this fetch address
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      timeouts = 1;
    end
    $display("retired %0d, mismatches %0d, protocol errors %0d, timeouts %0d",
             retired, mismatches, protocol_errors, timeouts);
    if (mismatches + protocol_errors + timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
source/core_cfg_pkg.sv
source/mips_isa_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/mips_core.sv
tests/core_checker.sv
tests/tb_mips_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line in the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mips_core -Mdir "$build_dir" -f verilog.f; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_mips_core" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$log_file"; then
  exit 0
fi
echo "pass line not found in $log_file"
exit 1
